// ==== run.sh ====
#!/bin/sh
# builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_ex_top -f vlog.f -o sim_ex_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_ex_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test passed$" sim.log; then
	exit 0
fi
exit 1

// ==== sim/tb_ex_model.svh ====
/*
 reference model for the execute stage testbench, included inside the testbench module
 holds the random generator and the expected-result function
*/
`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

typedef struct packed {
	logic        we;
	logic [4:0]  rd;
	logic [31:0] wdata;
	logic [31:0] pc_next;
	logic        err;
} exp_t;

logic [31:0] rng_state;    // LCG state, seeded by the testbench

function automatic logic [31:0] next_rand();
	rng_state = rng_state * 32'd1664525 + 32'd1013904223;
	return rng_state ^ (rng_state >> 16);    // fold the better high bits down
endfunction

// ------------------------------------------------------------
// expected result of one instruction, straight from the ISA rules
// ------------------------------------------------------------
function automatic exp_t expected_result(input logic [31:0] inst, input logic [31:0] pc,
	input logic [31:0] a, input logic [31:0] b);
	exp_t        e;
	logic [31:0] imm;
	logic [31:0] off;
	logic [31:0] rhs;
	logic [4:0]  sh;
	logic        taken;
	e.we      = 1'b0;
	e.rd      = inst[11:7];
	e.wdata   = 32'h0;
	e.pc_next = pc + 32'd4;
	e.err     = 1'b0;
	taken     = 1'b0;
	imm = {{20{inst[31]}}, inst[31:20]};
	off = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
	case (inst[6:0])
		7'b0010011, 7'b0110011: begin
			if (inst[5] && inst[31:25] != 7'h00 && inst[31:25] != 7'h20) begin
				e.err = 1'b1;    // funct7 outside the base set
			end else begin
				rhs  = inst[5] ? b : imm;    // bit 5 tells OP from OP-IMM
				sh   = rhs[4:0];
				e.we = 1'b1;
				case (inst[14:12])
					3'd0: e.wdata = (inst[5] && inst[30]) ? a - rhs : a + rhs;
					3'd1: e.wdata = a << sh;
					3'd2: e.wdata = {31'h0, $signed(a) < $signed(rhs)};
					3'd3: e.wdata = {31'h0, a < rhs};
					3'd4: e.wdata = a ^ rhs;
					3'd5: begin
						if (inst[30]) begin
							e.wdata = $signed(a) >>> sh;
						end else begin
							e.wdata = a >> sh;
						end
					end
					3'd6: e.wdata = a | rhs;
					default: e.wdata = a & rhs;
				endcase
			end
		end
		7'b1100011: begin
			case (inst[14:12])
				3'd0: taken = (a == b);
				3'd1: taken = (a != b);
				3'd4: taken = $signed(a) < $signed(b);
				3'd5: taken = $signed(a) >= $signed(b);
				3'd6: taken = a < b;
				3'd7: taken = a >= b;
				default: e.err = 1'b1;
			endcase
			if (taken) begin
				e.pc_next = pc + off;
			end
		end
		default: e.err = 1'b1;
	endcase
	return e;
endfunction

`endif

// ==== sim/tb_ex_top.sv ====
/*
 testbench for the pipelined execute stage
 random instructions from a fixed seed checked against the included model
*/
`timescale 1ns/1ps

module tb_ex_top;

	localparam int unsigned N_INST  = 3000;
	localparam int unsigned LATENCY = 2;    // register stages from drive to output

	`include "tb_ex_model.svh"

	typedef struct packed {
		exp_t        res;
		logic [31:0] due;    // cycle count when the result must show
	} pend_t;

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        inst_valid_i;
	logic [31:0] inst_i;
	logic [31:0] pc_i;
	logic [31:0] rs1_data_i;
	logic [31:0] rs2_data_i;
	logic        out_valid_o;
	logic        reg_we_o;
	logic [4:0]  reg_waddr_o;
	logic [31:0] reg_wdata_o;
	logic [31:0] pc_next_o;
	logic        inst_err_o;

	pend_t       exp_q[$];
	int unsigned cycle_cnt  = 0;
	int unsigned sent       = 0;
	int unsigned checked    = 0;
	int unsigned val_errs   = 0;
	int unsigned proto_errs = 0;
	int unsigned drain_errs = 0;
	logic [31:0] rnd;

	ex_top i_dut (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.rs1_data_i   (rs1_data_i),
		.rs2_data_i   (rs2_data_i),
		.out_valid_o  (out_valid_o),
		.reg_we_o     (reg_we_o),
		.reg_waddr_o  (reg_waddr_o),
		.reg_wdata_o  (reg_wdata_o),
		.pc_next_o    (pc_next_o),
		.inst_err_o   (inst_err_o)
	);

	always #2 clk = ~clk;    // 4 ns period

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	function automatic logic [31:0] gen_inst();
		logic [31:0] r;
		logic [31:0] k;
		r = next_rand();
		k = next_rand();
		case (k[31:30])
			2'd0: return {r[31:7], 7'b0010011};    // OP-IMM
			2'd1: begin
				if (k[29:27] == 3'd0) begin
					return {r[31:7], 7'b0110011};    // mostly a bad funct7
				end
				return {1'b0, k[26], 5'b0, r[24:7], 7'b0110011};
			end
			2'd2: return {r[31:7], 7'b1100011};    // branch
			default: return r;    // anything at all
		endcase
	endfunction

	task automatic drive_inst();
		logic [31:0] k;
		logic [31:0] r;
		pend_t       p;
		k = next_rand();
		r = next_rand();
		inst_i     = gen_inst();
		pc_i       = {r[31:2], 2'b00};
		rs1_data_i = next_rand();
		if (k[5:3] == 3'd0) begin
			rs1_data_i = {{28{k[6]}}, k[10:7]};    // near zero of either sign
		end
		rs2_data_i = (k[2:0] == 3'd0) ? rs1_data_i : next_rand();    // equal operands
		p.res = expected_result(inst_i, pc_i, rs1_data_i, rs2_data_i);
		p.due = cycle_cnt + LATENCY;
		exp_q.push_back(p);
	endtask

	// ------------------------------------------------------------
	// output checks on the falling edge
	// ------------------------------------------------------------
	task automatic check_output();
		pend_t p;
		assert (exp_q.size() != 0) else begin
			proto_errs++;
			$display("out_valid_o high with no instruction in flight");
		end
		if (exp_q.size() != 0) begin
			p = exp_q.pop_front();
			checked++;
			assert (p.due == cycle_cnt) else begin
				proto_errs++;
				$display("result showed at cycle %0d instead of cycle %0d", cycle_cnt, p.due);
			end
			assert (reg_we_o == p.res.we) else begin
				val_errs++;
				$display("[FAIL] reg_we_o got %h expected %h", reg_we_o, p.res.we);
			end
			assert (inst_err_o == p.res.err) else begin
				val_errs++;
				$display("[FAIL] inst_err_o got %h expected %h", inst_err_o, p.res.err);
			end
			assert (pc_next_o == p.res.pc_next) else begin
				val_errs++;
				$display("[FAIL] pc_next_o got %h expected %h", pc_next_o, p.res.pc_next);
			end
			if (p.res.we) begin
				assert (reg_waddr_o == p.res.rd) else begin
					val_errs++;
					$display("[FAIL] reg_waddr_o got %h expected %h", reg_waddr_o, p.res.rd);
				end
				assert (reg_wdata_o == p.res.wdata) else begin
					val_errs++;
					$display("[FAIL] reg_wdata_o got %h expected %h", reg_wdata_o, p.res.wdata);
				end
			end
		end
	endtask

	always @(negedge clk) begin
		if (cycle_cnt != 0) begin
			if (!rst_n_i) begin
				assert (out_valid_o == 1'b0) else begin
					proto_errs++;
					$display("out_valid_o high during reset");
				end
			end
			if (out_valid_o !== 1'b1) begin
				assert (reg_we_o == 1'b0 && inst_err_o == 1'b0) else begin
					proto_errs++;
					$display("reg_we_o or inst_err_o high while out_valid_o is low");
				end
				assert (exp_q.size() == 0 || exp_q[0].due > cycle_cnt) else begin
					proto_errs++;
					$display("no output for the instruction due at cycle %0d", exp_q[0].due);
					void'(exp_q.pop_front());
				end
			end else begin
				check_output();
			end
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = 32'h0;
		pc_i         = 32'h0;
		rs1_data_i   = 32'h0;
		rs2_data_i   = 32'h0;
		rng_state    = 32'hebc89a48;
		@(posedge clk);
		repeat (3) begin
			#1;
			inst_valid_i = 1'b1;    // strobes under reset must not reach the outputs
			inst_i       = next_rand();
			@(posedge clk);
		end
		#1;
		rst_n_i = 1'b1;
		while (sent < N_INST) begin
			rnd = next_rand();
			if (rnd[31:30] != 2'b00) begin    // about one cycle in four idle
				inst_valid_i = 1'b1;
				drive_inst();
				sent++;
			end else begin
				inst_valid_i = 1'b0;
				inst_i       = rnd;    // junk while idle
			end
			@(posedge clk);
			#1;
		end
		inst_valid_i = 1'b0;
		repeat (LATENCY + 1) @(posedge clk);
		@(negedge clk);
		assert (exp_q.size() == 0) else begin
			drain_errs++;
			$display("%0d instructions never produced a result", exp_q.size());
		end
		$display("checked %0d of %0d instructions: %0d value errors, %0d protocol errors, %0d lost",
			checked, sent, val_errs, proto_errs, drain_errs);
		if (val_errs + proto_errs + drain_errs == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// watchdog of ten cycles per instruction
	initial begin
		repeat (N_INST * 10 + 8) @(posedge clk);
		$display("timeout after %0d cycles, the run did not finish", cycle_cnt);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== verilog/ex_alu.sv ====
/*
 ALU and branch unit of the execute stage, purely combinational
 forms write-back data and the next instruction address
*/
`timescale 1ns/1ps

module ex_alu (
	input  ex_pkg::alu_op_e               alu_op_i,
	input  logic [ex_pkg::XLEN-1:0]       op_a_i,
	input  logic [ex_pkg::XLEN-1:0]       op_b_i,
	input  logic [2:0]                    br_funct3_i,
	input  logic [ex_pkg::XLEN-1:0]       br_offset_i,
	input  logic [ex_pkg::XLEN-1:0]       pc_i,
	input  logic [ex_pkg::REG_ADDR_W-1:0] rd_i,
	input  logic                          reg_we_i,
	input  logic                          illegal_i,
	output logic                          reg_we_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
	output logic [ex_pkg::XLEN-1:0]       wdata_o,
	output logic [ex_pkg::XLEN-1:0]       pc_next_o,
	output logic                          illegal_o
);
	import ex_pkg::*;

	logic               is_sub;
	logic [XLEN-1:0]    add_in2;
	logic [XLEN-1:0]    add_res;
	logic               op_sres;
	logic               op_ures;
	logic               op_eres;
	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0]    srl_res;
	logic [XLEN-1:0]    sra_res;
	logic               br_taken;
	logic [XLEN-1:0]    pc_inc;

	// ----------------------------------------------------------
	// shared arithmetic
	// ----------------------------------------------------------
	assign is_sub  = (alu_op_i == ALU_SUB);
	assign add_in2 = is_sub ? ~op_b_i : op_b_i;    // two's complement on SUB
	assign add_res = op_a_i + add_in2 + {{(XLEN-1){1'b0}}, is_sub};

	// comparator, a >= b
	assign op_sres = $signed(op_a_i) >= $signed(op_b_i);
	assign op_ures = op_a_i >= op_b_i;
	assign op_eres = (op_a_i == op_b_i);

	assign shamt   = op_b_i[SHAMT_W-1:0];
	assign srl_res = op_a_i >> shamt;
	assign sra_res = srl_res | ({XLEN{op_a_i[XLEN-1]}} & ~({XLEN{1'b1}} >> shamt));    // sign fill

	// ----------------------------------------------------------
	// write-back data
	// ----------------------------------------------------------
	always_comb begin
		case (alu_op_i)
			ALU_SLT:    wdata_o = {{(XLEN-1){1'b0}}, ~op_sres};
			ALU_SLTU:   wdata_o = {{(XLEN-1){1'b0}}, ~op_ures};
			ALU_XOR:    wdata_o = op_a_i ^ op_b_i;
			ALU_OR:     wdata_o = op_a_i | op_b_i;
			ALU_AND:    wdata_o = op_a_i & op_b_i;
			ALU_SLL:    wdata_o = op_a_i << shamt;
			ALU_SRL:    wdata_o = srl_res;
			ALU_SRA:    wdata_o = sra_res;
			ALU_BRANCH: wdata_o = '0;    // not written anyway
			default:    wdata_o = add_res;    // ADD, SUB
		endcase
	end

	// ----------------------------------------------------------
	// branch decision and next address
	// ----------------------------------------------------------
	always_comb begin
		br_taken = 1'b0;
		if (alu_op_i == ALU_BRANCH) begin
			case (br_funct3_i)
				F3_BEQ:  br_taken = op_eres;
				F3_BNE:  br_taken = ~op_eres;
				F3_BLT:  br_taken = ~op_sres;
				F3_BGE:  br_taken = op_sres;
				F3_BLTU: br_taken = ~op_ures;
				F3_BGEU: br_taken = op_ures;
				default: br_taken = 1'b0;
			endcase
		end
	end

	assign pc_inc    = br_taken ? br_offset_i : PC_STEP;
	assign pc_next_o = pc_i + pc_inc;    // second adder

	assign reg_we_o  = reg_we_i;
	assign rd_o      = rd_i;
	assign illegal_o = illegal_i;

endmodule

// ==== verilog/ex_decode.sv ====
/*
 instruction decoder of the execute stage, purely combinational
 splits the word, extends immediates and selects operands and ALU operation
*/
`timescale 1ns/1ps

module ex_decode (
	input  logic [ex_pkg::XLEN-1:0]       inst_i,         // instruction word
	input  logic [ex_pkg::XLEN-1:0]       pc_i,           // instruction address
	input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
	input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
	output ex_pkg::alu_op_e               alu_op_o,
	output logic [ex_pkg::XLEN-1:0]       op_a_o,
	output logic [ex_pkg::XLEN-1:0]       op_b_o,
	output logic [2:0]                    br_funct3_o,    // branch condition
	output logic [ex_pkg::XLEN-1:0]       br_offset_o,    // B-type offset
	output logic [ex_pkg::XLEN-1:0]       pc_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] rd_o,
	output logic                          reg_we_o,
	output logic                          illegal_o
);
	import ex_pkg::*;

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_b;

	// ----------------------------------------------------------
	// field split and immediates
	// ----------------------------------------------------------
	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];

	assign imm_i = {{(XLEN-12){inst_i[31]}}, inst_i[31:20]};
	assign imm_b = {{(XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
		inst_i[30:25], inst_i[11:8], 1'b0};    // offset in half words

	assign rd_o        = inst_i[11:7];
	assign pc_o        = pc_i;
	assign br_funct3_o = funct3;
	assign br_offset_o = imm_b;

	// shared by I-type and R-type, alt is bit 30 where it means SUB / SRA
	function automatic alu_op_e alu_op_sel(input logic [2:0] f3, input logic alt);
		case (f3)
			F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     return ALU_SLL;
			F3_SLT:     return ALU_SLT;
			F3_SLTU:    return ALU_SLTU;
			F3_XOR:     return ALU_XOR;
			F3_SR:      return alt ? ALU_SRA : ALU_SRL;
			F3_OR:      return ALU_OR;
			default:    return ALU_AND;
		endcase
	endfunction

	// ----------------------------------------------------------
	// operand and operation select
	// ----------------------------------------------------------
	always_comb begin
		alu_op_o  = ALU_ADD;
		op_a_o    = rs1_data_i;    // rs1 is always operand a
		op_b_o    = rs2_data_i;
		reg_we_o  = 1'b0;
		illegal_o = 1'b0;
		case (opcode)
			OPC_OP_IMM: begin
				op_b_o   = imm_i;    // shamt sits in imm_i[4:0]
				// bit 30 is part of the immediate except on SRAI
				alu_op_o = alu_op_sel(funct3, inst_i[30] & (funct3 == F3_SR));
				reg_we_o = 1'b1;
			end
			OPC_OP: begin
				if ((funct7 == F7_BASE) || (funct7 == F7_ALT)) begin
					alu_op_o = alu_op_sel(funct3, inst_i[30]);
					reg_we_o = 1'b1;
				end else begin
					illegal_o = 1'b1;    // M extension and others
				end
			end
			OPC_BRANCH: begin
				if (funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
					alu_op_o = ALU_BRANCH;    // compare rs1 with rs2
				end else begin
					illegal_o = 1'b1;
				end
			end
			default: begin
				illegal_o = 1'b1;
			end
		endcase
	end

endmodule

// ==== verilog/ex_pkg.sv ====
/*
 common definitions for the pipelined RV32I execute stage
 imported by decoder, ALU and top level
*/
package ex_pkg;

	// ----------------------------------------------------------
	// widths
	// ----------------------------------------------------------
	localparam int XLEN       = 32;    // RV32I register word
	localparam int REG_ADDR_W = 5;     // x0..x31
	localparam int SHAMT_W    = 5;     // low bits of rs2 / imm

	localparam logic [XLEN-1:0] PC_STEP = 4;    // sequential fetch step

	// ----------------------------------------------------------
	// opcodes and function codes
	// ----------------------------------------------------------
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;    // also ADDI
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SR      = 3'b101;    // SRL and SRA, bit 30 picks
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// branch conditions are the funct3 values themselves
	localparam logic [2:0] F3_BEQ  = 3'b000;
	localparam logic [2:0] F3_BNE  = 3'b001;
	localparam logic [2:0] F3_BLT  = 3'b100;
	localparam logic [2:0] F3_BGE  = 3'b101;
	localparam logic [2:0] F3_BLTU = 3'b110;
	localparam logic [2:0] F3_BGEU = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB / SRA

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
		ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_BRANCH
	} alu_op_e;

	// ----------------------------------------------------------
	// pipeline payloads
	// ----------------------------------------------------------
	typedef struct packed {
		alu_op_e               alu_op;
		logic [XLEN-1:0]       op_a;
		logic [XLEN-1:0]       op_b;
		logic [2:0]            br_funct3;
		logic [XLEN-1:0]       br_offset;
		logic [XLEN-1:0]       pc;
		logic [REG_ADDR_W-1:0] rd;
		logic                  reg_we;
		logic                  illegal;
	} dec_s;

	typedef struct packed {
		logic                  reg_we;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       wdata;
		logic [XLEN-1:0]       pc_next;
		logic                  illegal;
	} res_s;

endpackage

// ==== verilog/ex_stage_reg.sv ====
/*
 valid-qualified pipeline register, payload given by type parameter
 used after the decoder and again after the ALU
*/
`timescale 1ns/1ps

module ex_stage_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n_i,
	input  logic     valid_i,
	input  payload_t data_i,
	output logic     valid_o,
	output payload_t data_o
);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;    // one cycle behind the strobe
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			data_o <= data_i;    // hold between strobes
		end
	end

endmodule

// ==== verilog/ex_top.sv ====
/*
 pipelined RV32I execute stage, fixed latency of two cycles
 decode -> stage register -> ALU -> stage register -> outputs
*/
`timescale 1ns/1ps

module ex_top (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          inst_valid_i,    // one strobe per instruction
	input  logic [ex_pkg::XLEN-1:0]       inst_i,
	input  logic [ex_pkg::XLEN-1:0]       pc_i,
	input  logic [ex_pkg::XLEN-1:0]       rs1_data_i,
	input  logic [ex_pkg::XLEN-1:0]       rs2_data_i,
	output logic                          out_valid_o,
	output logic                          reg_we_o,
	output logic [ex_pkg::REG_ADDR_W-1:0] reg_waddr_o,
	output logic [ex_pkg::XLEN-1:0]       reg_wdata_o,
	output logic [ex_pkg::XLEN-1:0]       pc_next_o,
	output logic                          inst_err_o
);
	import ex_pkg::*;

	dec_s dec_d;
	dec_s dec_q;
	logic dec_valid_q;
	res_s res_d;
	res_s res_q;

	ex_decode i_decode (
		.inst_i      (inst_i),
		.pc_i        (pc_i),
		.rs1_data_i  (rs1_data_i),
		.rs2_data_i  (rs2_data_i),
		.alu_op_o    (dec_d.alu_op),
		.op_a_o      (dec_d.op_a),
		.op_b_o      (dec_d.op_b),
		.br_funct3_o (dec_d.br_funct3),
		.br_offset_o (dec_d.br_offset),
		.pc_o        (dec_d.pc),
		.rd_o        (dec_d.rd),
		.reg_we_o    (dec_d.reg_we),
		.illegal_o   (dec_d.illegal)
	);

	ex_stage_reg #(.payload_t(dec_s)) i_dec_reg (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.valid_i (inst_valid_i),
		.data_i  (dec_d),
		.valid_o (dec_valid_q),
		.data_o  (dec_q)
	);

	ex_alu i_alu (
		.alu_op_i    (dec_q.alu_op),
		.op_a_i      (dec_q.op_a),
		.op_b_i      (dec_q.op_b),
		.br_funct3_i (dec_q.br_funct3),
		.br_offset_i (dec_q.br_offset),
		.pc_i        (dec_q.pc),
		.rd_i        (dec_q.rd),
		.reg_we_i    (dec_q.reg_we),
		.illegal_i   (dec_q.illegal),
		.reg_we_o    (res_d.reg_we),
		.rd_o        (res_d.rd),
		.wdata_o     (res_d.wdata),
		.pc_next_o   (res_d.pc_next),
		.illegal_o   (res_d.illegal)
	);

	ex_stage_reg #(.payload_t(res_s)) i_res_reg (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.valid_i (dec_valid_q),
		.data_i  (res_d),
		.valid_o (out_valid_o),
		.data_o  (res_q)
	);

	// flags only count while the result slot is valid
	assign reg_we_o    = out_valid_o & res_q.reg_we;
	assign inst_err_o  = out_valid_o & res_q.illegal;
	assign reg_waddr_o = res_q.rd;
	assign reg_wdata_o = res_q.wdata;
	assign pc_next_o   = res_q.pc_next;

endmodule

// ==== vlog.f ====
+incdir+sim
verilog/ex_pkg.sv
verilog/ex_decode.sv
verilog/ex_stage_reg.sv
verilog/ex_alu.sv
verilog/ex_top.sv
sim/tb_ex_top.sv
